/* include/csr_fields.svh */
`ifndef CSR_FIELDS_SVH
`define CSR_FIELDS_SVH

// CRMD
`define CSR_CRMD_PLV        1:0
`define CSR_CRMD_IE         2
`define CSR_CRMD_DA         3

// PRMD
`define CSR_PRMD_PPLV       1:0
`define CSR_PRMD_PIE        2

// ECFG
`define CSR_ECFG_LIE        12:0

// ESTAT
`define CSR_ESTAT_IS        12:0
`define CSR_ESTAT_IS10      1:0
`define CSR_ESTAT_ECODE     21:16
`define CSR_ESTAT_ESUBCODE  30:22

// EENTRY, low 6 bits read zero
`define CSR_EENTRY_VA       31:6

// TCFG
`define CSR_TCFG_EN         0
`define CSR_TCFG_PERIOD     1
`define CSR_TCFG_INITV      31:2

// TICLR
`define CSR_TICLR_CLR       0

`endif

/* logic/csr_int_ctrl.sv */
`timescale 1ns/1ps
`include "csr_fields.svh"

module csr_int_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  priv_pkg::csr_access_t csr_acc,
    input  priv_pkg::wb_exc_t     wb,
    input  logic                  crmd_ie,
    input  logic [7:0]            hw_int,
    input  logic                  ipi_int,
    input  logic                  timer_fire,
    output logic [31:0]           int_rdata,
    output logic                  has_int
);
    import priv_pkg::*;

    int_vec_t    estat_is;
    int_vec_t    ecfg_lie;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] estat_word;
    logic [31:0] ecfg_word;
    logic [31:0] estat_next;
    logic [31:0] ecfg_next;
    logic        ticlr_clr;

    always_comb begin
        estat_word = '0;
        estat_word[`CSR_ESTAT_IS] = estat_is;
        estat_word[`CSR_ESTAT_ECODE] = estat_ecode;
        estat_word[`CSR_ESTAT_ESUBCODE] = estat_esubcode;
        ecfg_word = '0;
        ecfg_word[`CSR_ECFG_LIE] = ecfg_lie;
    end

    assign estat_next = csr_merge(estat_word, csr_acc.wvalue, csr_acc.wmask);
    assign ecfg_next  = csr_merge(ecfg_word, csr_acc.wvalue, csr_acc.wmask);
    assign ticlr_clr  = csr_acc.we && csr_acc.num == CSR_TICLR
                        && csr_acc.wmask[`CSR_TICLR_CLR] && csr_acc.wvalue[`CSR_TICLR_CLR];

    // Hardware and IPI lines resampled every cycle, timer bit held until cleared
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is <= '0;
        end else begin
            if (csr_acc.we && csr_acc.num == CSR_ESTAT) begin
                estat_is[1:0] <= estat_next[`CSR_ESTAT_IS10];
            end
            estat_is[9:2] <= hw_int;
            estat_is[10]  <= 1'b0;
            if (timer_fire) begin
                estat_is[11] <= 1'b1;
            end else if (ticlr_clr) begin
                estat_is[11] <= 1'b0;
            end
            estat_is[12] <= ipi_int;
        end
    end

    always_ff @(posedge clk) begin
        if (wb.ex) begin
            estat_ecode    <= wb.ecode;
            estat_esubcode <= wb.esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie <= '0;
        end else if (csr_acc.we && csr_acc.num == CSR_ECFG) begin
            ecfg_lie <= ecfg_next[`CSR_ECFG_LIE];
        end
    end

    // TICLR reads zero through the default
    always_comb begin
        case (csr_acc.num)
            CSR_ESTAT: int_rdata = estat_word;
            CSR_ECFG:  int_rdata = ecfg_word;
            default:   int_rdata = '0;
        endcase
    end

    assign has_int = |(estat_is & ecfg_lie) && crmd_ie;

endmodule

/* logic/csr_regfile.sv */
`timescale 1ns/1ps
`include "csr_fields.svh"

module csr_regfile #(
    parameter int SAVE_REGS = 4
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  priv_pkg::csr_access_t csr_acc,
    input  priv_pkg::wb_exc_t     wb,
    input  logic [31:0]           coreid,
    input  logic [31:0]           timer_rdata,
    input  logic [31:0]           int_rdata,
    output logic                  crmd_ie,
    output logic [31:0]           csr_rvalue,
    output logic [31:0]           ex_entry,
    output logic [31:0]           era_pc
);
    import priv_pkg::*;

    logic [1:0]           crmd_plv;
    logic [1:0]           prmd_pplv;
    logic                 prmd_pie;
    logic [31:0]          era_q;
    logic [25:0]          eentry_va;
    logic [31:0]          save_q [SAVE_REGS];
    logic [SAVE_REGS-1:0] save_sel;
    logic [31:0]          badv_q;
    logic [31:0]          tid_q;

    logic [31:0] crmd_word;
    logic [31:0] prmd_word;
    logic [31:0] eentry_word;
    logic [31:0] crmd_next;
    logic [31:0] prmd_next;
    logic [31:0] eentry_next;
    logic        crmd_we;
    logic        prmd_we;
    logic        era_we;
    logic        eentry_we;
    logic        badv_we;
    logic        tid_we;
    logic        addr_err;
    logic [31:0] save_rdata;
    logic [31:0] local_rdata;

    assign crmd_we   = csr_acc.we && csr_acc.num == CSR_CRMD;
    assign prmd_we   = csr_acc.we && csr_acc.num == CSR_PRMD;
    assign era_we    = csr_acc.we && csr_acc.num == CSR_ERA;
    assign eentry_we = csr_acc.we && csr_acc.num == CSR_EENTRY;
    assign badv_we   = csr_acc.we && csr_acc.num == CSR_BADV;
    assign tid_we    = csr_acc.we && csr_acc.num == CSR_TID;

    // Direct address mode only, PG and DAT fields stay zero
    always_comb begin
        crmd_word = '0;
        crmd_word[`CSR_CRMD_DA] = 1'b1;
        crmd_word[`CSR_CRMD_IE] = crmd_ie;
        crmd_word[`CSR_CRMD_PLV] = crmd_plv;
    end

    always_comb begin
        prmd_word = '0;
        prmd_word[`CSR_PRMD_PIE] = prmd_pie;
        prmd_word[`CSR_PRMD_PPLV] = prmd_pplv;
    end

    assign eentry_word = {eentry_va, 6'b0};

    assign crmd_next   = csr_merge(crmd_word, csr_acc.wvalue, csr_acc.wmask);
    assign prmd_next   = csr_merge(prmd_word, csr_acc.wvalue, csr_acc.wmask);
    assign eentry_next = csr_merge(eentry_word, csr_acc.wvalue, csr_acc.wmask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (crmd_we) begin
            crmd_plv <= crmd_next[`CSR_CRMD_PLV];
            crmd_ie  <= crmd_next[`CSR_CRMD_IE];
        end
    end

    // Previous mode saved on exception entry
    always_ff @(posedge clk) begin
        if (wb.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (prmd_we) begin
            prmd_pplv <= prmd_next[`CSR_PRMD_PPLV];
            prmd_pie  <= prmd_next[`CSR_PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (wb.ex) begin
            era_q <= wb.pc;
        end else if (era_we) begin
            era_q <= csr_merge(era_q, csr_acc.wvalue, csr_acc.wmask);
        end
    end

    always_ff @(posedge clk) begin
        if (eentry_we) begin
            eentry_va <= eentry_next[`CSR_EENTRY_VA];
        end
    end

    // Fetch errors report the PC, other address errors the data address
    assign addr_err = wb.ecode == ECODE_ADE || wb.ecode == ECODE_ALE;

    always_ff @(posedge clk) begin
        if (wb.ex && addr_err) begin
            if (wb.ecode == ECODE_ADE && wb.esubcode == ESUBCODE_ADEF) begin
                badv_q <= wb.pc;
            end else begin
                badv_q <= wb.vaddr;
            end
        end else if (badv_we) begin
            badv_q <= csr_merge(badv_q, csr_acc.wvalue, csr_acc.wmask);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tid_q <= coreid;
        end else if (tid_we) begin
            tid_q <= csr_merge(tid_q, csr_acc.wvalue, csr_acc.wmask);
        end
    end

    for (genvar i = 0; i < SAVE_REGS; i++) begin : g_save
        assign save_sel[i] = csr_acc.num == 14'(CSR_SAVE0 + i);

        always_ff @(posedge clk) begin
            if (csr_acc.we && save_sel[i]) begin
                save_q[i] <= csr_merge(save_q[i], csr_acc.wvalue, csr_acc.wmask);
            end
        end
    end

    always_comb begin
        save_rdata = '0;
        for (int i = 0; i < SAVE_REGS; i++) begin
            if (save_sel[i]) begin
                save_rdata = save_q[i];
            end
        end
    end

    always_comb begin
        case (csr_acc.num)
            CSR_CRMD:   local_rdata = crmd_word;
            CSR_PRMD:   local_rdata = prmd_word;
            CSR_ERA:    local_rdata = era_q;
            CSR_EENTRY: local_rdata = eentry_word;
            CSR_BADV:   local_rdata = badv_q;
            CSR_TID:    local_rdata = tid_q;
            default:    local_rdata = save_rdata;
        endcase
    end

    // Timer and interrupt words are zero outside their own numbers
    assign csr_rvalue = local_rdata | timer_rdata | int_rdata;
    assign ex_entry   = eentry_word;
    assign era_pc     = era_q;

endmodule

/* logic/csr_timer.sv */
`timescale 1ns/1ps
`include "csr_fields.svh"

module csr_timer (
    input  logic                  clk,
    input  logic                  resetn,
    input  priv_pkg::csr_access_t csr_acc,
    output logic [31:0]           timer_rdata,
    output logic                  timer_fire
);
    import priv_pkg::*;

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initv;
    logic [31:0] timer_cnt;
    logic [31:0] tcfg_word;
    logic [31:0] tcfg_next;
    logic        tcfg_we;

    assign tcfg_we = csr_acc.we && csr_acc.num == CSR_TCFG;

    always_comb begin
        tcfg_word = '0;
        tcfg_word[`CSR_TCFG_EN] = tcfg_en;
        tcfg_word[`CSR_TCFG_PERIOD] = tcfg_periodic;
        tcfg_word[`CSR_TCFG_INITV] = tcfg_initv;
    end

    // Merged value lets an enabling write start with its own INITV
    assign tcfg_next = csr_merge(tcfg_word, csr_acc.wvalue, csr_acc.wmask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en <= 1'b0;
        end else if (tcfg_we) begin
            tcfg_en <= tcfg_next[`CSR_TCFG_EN];
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_we) begin
            tcfg_periodic <= tcfg_next[`CSR_TCFG_PERIOD];
            tcfg_initv    <= tcfg_next[`CSR_TCFG_INITV];
        end
    end

    // All ones marks a stopped one-shot count
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= '1;
        end else if (tcfg_we && tcfg_next[`CSR_TCFG_EN]) begin
            timer_cnt <= {tcfg_next[`CSR_TCFG_INITV], 2'b0};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initv, 2'b0};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    assign timer_fire = tcfg_en && timer_cnt == '0;

    always_comb begin
        case (csr_acc.num)
            CSR_TCFG: timer_rdata = tcfg_word;
            CSR_TVAL: timer_rdata = timer_cnt;
            default:  timer_rdata = '0;
        endcase
    end

endmodule

/* logic/priv_pkg.sv */
package priv_pkg;

    // CSR numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ECFG   = 14'h004;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    // SAVE1 and up follow at consecutive numbers
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_TID    = 14'h040;
    localparam logic [13:0] CSR_TCFG   = 14'h041;
    localparam logic [13:0] CSR_TVAL   = 14'h042;
    localparam logic [13:0] CSR_TICLR  = 14'h044;

    // Exception codes
    localparam logic [5:0] ECODE_INT     = 6'h00;
    localparam logic [5:0] ECODE_ADE     = 6'h08;
    localparam logic [5:0] ECODE_ALE     = 6'h09;
    localparam logic [5:0] ECODE_SYS     = 6'h0b;
    localparam logic [8:0] ESUBCODE_ADEF = 9'h000;

    // One CSR access from the core
    typedef struct packed {
        logic [13:0] num;
        logic        we;
        logic [31:0] wmask;
        logic [31:0] wvalue;
    } csr_access_t;

    // Exception or ertn at write-back
    typedef struct packed {
        logic        ex;
        logic        ertn;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
        logic [31:0] vaddr;
    } wb_exc_t;

    // 1:0 software, 9:2 hardware, 11 timer, 12 IPI
    typedef logic [12:0] int_vec_t;

    // Masked write: value where mask is set, old bits elsewhere
    function automatic logic [31:0] csr_merge(
        input logic [31:0] old_val,
        input logic [31:0] wvalue,
        input logic [31:0] wmask
    );
        return (wmask & wvalue) | (~wmask & old_val);
    endfunction

endpackage

/* logic/priv_unit.sv */
`timescale 1ns/1ps

module priv_unit #(
    parameter int SAVE_REGS = 4
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  priv_pkg::csr_access_t csr_acc,
    input  priv_pkg::wb_exc_t     wb,
    input  logic [7:0]            hw_int,
    input  logic                  ipi_int,
    input  logic [31:0]           coreid,
    output logic [31:0]           csr_rvalue,
    output logic [31:0]           ex_entry,
    output logic [31:0]           era_pc,
    output logic                  has_int
);

    logic [31:0] timer_rdata;
    logic [31:0] int_rdata;
    logic        timer_fire;
    logic        crmd_ie;

    csr_regfile #(
        .SAVE_REGS (SAVE_REGS)
    ) i_regfile (
        .clk         (clk),
        .resetn      (resetn),
        .csr_acc     (csr_acc),
        .wb          (wb),
        .coreid      (coreid),
        .timer_rdata (timer_rdata),
        .int_rdata   (int_rdata),
        .crmd_ie     (crmd_ie),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .era_pc      (era_pc)
    );

    csr_timer i_timer (
        .clk         (clk),
        .resetn      (resetn),
        .csr_acc     (csr_acc),
        .timer_rdata (timer_rdata),
        .timer_fire  (timer_fire)
    );

    csr_int_ctrl i_int_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .csr_acc    (csr_acc),
        .wb         (wb),
        .crmd_ie    (crmd_ie),
        .hw_int     (hw_int),
        .ipi_int    (ipi_int),
        .timer_fire (timer_fire),
        .int_rdata  (int_rdata),
        .has_int    (has_int)
    );

endmodule

/* priv_unit.f */
+incdir+include
logic/priv_pkg.sv
logic/csr_regfile.sv
logic/csr_timer.sv
logic/csr_int_ctrl.sv
logic/priv_unit.sv
test/priv_unit_props.sv
test/priv_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f priv_unit.f --top-module priv_unit_tb \
    -o sim_priv_unit || { echo "Build failed"; exit 1; }
output=$(./obj_dir/sim_priv_unit)
echo "$output"
echo "$output" | grep -qx "TEST PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* test/priv_unit_props.sv */
`timescale 1ns/1ps

module priv_unit_props (
    input logic               clk,
    input logic               resetn,
    input logic               timer_fire,
    input logic [7:0]         hw_int,
    input logic               ipi_int,
    input priv_pkg::int_vec_t estat_is,
    input logic               has_int
);

    int err_count = 0;

    // Hardware and IPI lines land in IS one edge later
    a_int_sampled: assert property (@(posedge clk) disable iff (!resetn)
                                    1'b1 |=> estat_is[9:2] == $past(hw_int)
                                             && estat_is[12] == $past(ipi_int))
        else begin
            $error("ESTAT.IS does not follow hw_int and ipi_int after one edge");
            err_count++;
        end

    a_reset_quiet: assert property (@(posedge clk) !resetn |=> !has_int)
        else begin
            $error("has_int high in the cycle after reset");
            err_count++;
        end

    // Timer expiry latches into IS bit 11
    a_timer_latch: assert property (@(posedge clk) disable iff (!resetn)
                                    timer_fire |=> estat_is[11])
        else begin
            $error("timer_fire not followed by ESTAT.IS bit 11");
            err_count++;
        end

endmodule

bind csr_int_ctrl priv_unit_props i_props (
    .clk        (clk),
    .resetn     (resetn),
    .timer_fire (timer_fire),
    .hw_int     (hw_int),
    .ipi_int    (ipi_int),
    .estat_is   (estat_is),
    .has_int    (has_int)
);

/* test/priv_unit_tb.sv */
`timescale 1ns/1ps

module priv_unit_tb;
    import priv_pkg::*;

    typedef enum logic [3:0] {
        OP_WR, OP_RD, OP_EXC, OP_ERTN, OP_IRQ, OP_INT, OP_WAIT, OP_ENTRY, OP_ERA
    } op_t;

    // One table row, exp compared on chk bits only
    typedef struct packed {
        op_t         op;
        logic [13:0] num;
        logic [31:0] mask;
        logic [31:0] value;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic [31:0] exp;
        logic [31:0] chk;
    } step_t;

    localparam logic [31:0] CORE_ID = 32'h0000_0005;
    localparam int WAIT_CYCLES = 25;

    logic        clk;
    logic        resetn;
    csr_access_t csr_acc;
    wb_exc_t     wb;
    logic [7:0]  hw_int;
    logic        ipi_int;
    logic [31:0] coreid;
    logic [31:0] csr_rvalue;
    logic [31:0] ex_entry;
    logic [31:0] era_pc;
    logic        has_int;

    step_t       steps[$];
    string       names[$];
    logic [31:0] lcg_state;
    int          watchdog_cycles;
    logic        table_ready;

    priv_unit #(
        .SAVE_REGS (4)
    ) i_dut (
        .clk        (clk),
        .resetn     (resetn),
        .csr_acc    (csr_acc),
        .wb         (wb),
        .hw_int     (hw_int),
        .ipi_int    (ipi_int),
        .coreid     (coreid),
        .csr_rvalue (csr_rvalue),
        .ex_entry   (ex_entry),
        .era_pc     (era_pc),
        .has_int    (has_int)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] masked(input logic [31:0] old, input logic [31:0] value,
                                           input logic [31:0] mask);
        return (old & ~mask) | (value & mask);
    endfunction

    task automatic push_row(input string name, input op_t op, input logic [13:0] num,
                            input logic [31:0] mask, input logic [31:0] value,
                            input logic [31:0] exp, input logic [31:0] chk);
        step_t s;
        s = '0;
        s.op = op;
        s.num = num;
        s.mask = mask;
        s.value = value;
        s.exp = exp;
        s.chk = chk;
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic exc_row(input string name, input logic [5:0] ecode, input logic [8:0] esub,
                           input logic [31:0] pc, input logic [31:0] vaddr);
        step_t s;
        s = '0;
        s.op = OP_EXC;
        s.ecode = ecode;
        s.esubcode = esub;
        s.pc = pc;
        s.vaddr = vaddr;
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic build_table();
        logic [31:0] init_val [4];
        logic [31:0] save_exp [4];
        logic [31:0] m;
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] pc;
        logic [31:0] va;
        push_row("tid reset", OP_RD, CSR_TID, 0, 0, CORE_ID, '1);
        push_row("crmd reset", OP_RD, CSR_CRMD, 0, 0, 32'h8, '1);
        push_row("ecfg reset", OP_RD, CSR_ECFG, 0, 0, 0, '1);
        push_row("estat is reset", OP_RD, CSR_ESTAT, 0, 0, 0, 32'h1fff);
        push_row("tval reset", OP_RD, CSR_TVAL, 0, 0, '1, '1);
        for (int i = 0; i < 4; i++) begin
            init_val[i] = lcg_next();
            push_row($sformatf("save%0d full", i), OP_WR, CSR_SAVE0 + 14'(i), '1, init_val[i],
                     0, 0);
        end
        for (int i = 0; i < 4; i++) begin
            m = lcg_next();
            v = lcg_next();
            save_exp[i] = masked(init_val[i], v, m);
            push_row($sformatf("save%0d masked", i), OP_WR, CSR_SAVE0 + 14'(i), m, v, 0, 0);
        end
        for (int i = 0; i < 4; i++) begin
            push_row($sformatf("save%0d read", i), OP_RD, CSR_SAVE0 + 14'(i), 0, 0,
                     save_exp[i], '1);
        end
        v = lcg_next();
        m = lcg_next();
        w = lcg_next();
        push_row("era full", OP_WR, CSR_ERA, '1, v, 0, 0);
        push_row("era masked", OP_WR, CSR_ERA, m, w, 0, 0);
        push_row("era read", OP_RD, CSR_ERA, 0, 0, masked(v, w, m), '1);
        v = lcg_next();
        push_row("eentry write", OP_WR, CSR_EENTRY, '1, v, 0, 0);
        push_row("eentry read", OP_RD, CSR_EENTRY, 0, 0, v & 32'hffff_ffc0, '1);
        push_row("ex_entry port", OP_ENTRY, '0, 0, 0, v & 32'hffff_ffc0, '1);
        m = lcg_next();
        v = lcg_next();
        push_row("crmd masked", OP_WR, CSR_CRMD, m, v, 0, 0);
        push_row("crmd read", OP_RD, CSR_CRMD, 0, 0, (masked(32'h8, v, m) & 32'h7) | 32'h8, '1);
        // Exception entry for ADEF, ALE and SYS
        pc = lcg_next();
        va = lcg_next();
        push_row("crmd plv3 ie", OP_WR, CSR_CRMD, 32'h7, 32'h7, 0, 0);
        exc_row("adef entry", ECODE_ADE, ESUBCODE_ADEF, pc, va);
        push_row("adef crmd", OP_RD, CSR_CRMD, 0, 0, 32'h8, '1);
        push_row("adef prmd", OP_RD, CSR_PRMD, 0, 0, 32'h7, '1);
        push_row("adef era", OP_RD, CSR_ERA, 0, 0, pc, '1);
        push_row("adef era_pc", OP_ERA, '0, 0, 0, pc, '1);
        push_row("adef estat", OP_RD, CSR_ESTAT, 0, 0,
                 {1'b0, ESUBCODE_ADEF, ECODE_ADE, 16'h0}, 32'h7fff_0000);
        push_row("adef badv", OP_RD, CSR_BADV, 0, 0, pc, '1);
        pc = lcg_next();
        va = lcg_next();
        exc_row("ale entry", ECODE_ALE, 9'h0, pc, va);
        push_row("ale prmd", OP_RD, CSR_PRMD, 0, 0, 32'h0, '1);
        push_row("ale estat", OP_RD, CSR_ESTAT, 0, 0, {1'b0, 9'h0, ECODE_ALE, 16'h0},
                 32'h7fff_0000);
        push_row("ale badv", OP_RD, CSR_BADV, 0, 0, va, '1);
        w = va;
        pc = lcg_next();
        va = lcg_next();
        push_row("crmd plv3 ie again", OP_WR, CSR_CRMD, 32'h7, 32'h7, 0, 0);
        exc_row("sys entry", ECODE_SYS, 9'h0, pc, va);
        push_row("sys badv kept", OP_RD, CSR_BADV, 0, 0, w, '1);
        push_row("sys era", OP_RD, CSR_ERA, 0, 0, pc, '1);
        push_row("sys estat", OP_RD, CSR_ESTAT, 0, 0, {1'b0, 9'h0, ECODE_SYS, 16'h0},
                 32'h7fff_0000);
        push_row("ertn", OP_ERTN, '0, 0, 0, 0, 0);
        push_row("ertn crmd", OP_RD, CSR_CRMD, 0, 0, 32'hf, '1);
        push_row("prmd plv1", OP_WR, CSR_PRMD, 32'h7, 32'h1, 0, 0);
        push_row("ertn plv1", OP_ERTN, '0, 0, 0, 0, 0);
        push_row("ertn plv1 crmd", OP_RD, CSR_CRMD, 0, 0, 32'h9, '1);
        // Software, hardware and IPI sources
        push_row("sw is set", OP_WR, CSR_ESTAT, 32'h3, 32'h1, 0, 0);
        push_row("ie on", OP_WR, CSR_CRMD, 32'h4, 32'h4, 0, 0);
        push_row("sw masked by lie", OP_INT, '0, 0, 0, 0, 1);
        push_row("lie sw", OP_WR, CSR_ECFG, 32'h1fff, 32'h1, 0, 0);
        push_row("sw int", OP_INT, '0, 0, 0, 1, 1);
        push_row("ie off", OP_WR, CSR_CRMD, 32'h4, 32'h0, 0, 0);
        push_row("sw ie off", OP_INT, '0, 0, 0, 0, 1);
        push_row("ie on again", OP_WR, CSR_CRMD, 32'h4, 32'h4, 0, 0);
        push_row("sw clear", OP_WR, CSR_ESTAT, 32'h3, 32'h0, 0, 0);
        push_row("sw cleared", OP_INT, '0, 0, 0, 0, 1);
        push_row("lie hw4", OP_WR, CSR_ECFG, 32'h1fff, 32'h40, 0, 0);
        push_row("hw0 raise", OP_IRQ, '0, 0, 32'h01, 0, 0);
        push_row("hw0 masked", OP_INT, '0, 0, 0, 0, 1);
        push_row("hw4 raise", OP_IRQ, '0, 0, 32'h10, 0, 0);
        push_row("hw4 int", OP_INT, '0, 0, 0, 1, 1);
        push_row("hw4 drop", OP_IRQ, '0, 0, 32'h00, 0, 0);
        push_row("hw4 gone", OP_INT, '0, 0, 0, 0, 1);
        push_row("lie ipi", OP_WR, CSR_ECFG, 32'h1fff, 32'h1000, 0, 0);
        push_row("ipi raise", OP_IRQ, '0, 0, 32'h100, 0, 0);
        push_row("ipi int", OP_INT, '0, 0, 0, 1, 1);
        push_row("ipi estat", OP_RD, CSR_ESTAT, 0, 0, 32'h1000, 32'h1000);
        push_row("ipi drop", OP_IRQ, '0, 0, 32'h000, 0, 0);
        push_row("ipi gone", OP_INT, '0, 0, 0, 0, 1);
        // Timer, INITV 5 counts from 20
        push_row("lie timer", OP_WR, CSR_ECFG, 32'h1fff, 32'h800, 0, 0);
        push_row("tcfg periodic", OP_WR, CSR_TCFG, '1, 32'h17, 0, 0);
        push_row("tval 20", OP_RD, CSR_TVAL, 0, 0, 32'd20, '1);
        push_row("tval 19", OP_RD, CSR_TVAL, 0, 0, 32'd19, '1);
        push_row("tval 18", OP_RD, CSR_TVAL, 0, 0, 32'd18, '1);
        push_row("timer int", OP_WAIT, '0, 0, WAIT_CYCLES, 0, 0);
        push_row("ticlr first", OP_WR, CSR_TICLR, 32'h1, 32'h1, 0, 0);
        push_row("timer cleared", OP_INT, '0, 0, 0, 0, 1);
        push_row("timer periodic again", OP_WAIT, '0, 0, WAIT_CYCLES, 0, 0);
        push_row("ticlr second", OP_WR, CSR_TICLR, 32'h1, 32'h1, 0, 0);
        push_row("timer cleared again", OP_INT, '0, 0, 0, 0, 1);
        push_row("timer periodic third", OP_WAIT, '0, 0, WAIT_CYCLES, 0, 0);
        push_row("ticlr third", OP_WR, CSR_TICLR, 32'h1, 32'h1, 0, 0);
        push_row("tcfg one shot", OP_WR, CSR_TCFG, '1, 32'h9, 0, 0);
        push_row("one shot int", OP_WAIT, '0, 0, WAIT_CYCLES, 0, 0);
        push_row("one shot tval", OP_RD, CSR_TVAL, 0, 0, '1, '1);
        push_row("one shot tcfg", OP_RD, CSR_TCFG, 0, 0, 32'h9, '1);
        push_row("ticlr one shot", OP_WR, CSR_TICLR, 32'h1, 32'h1, 0, 0);
        push_row("one shot cleared", OP_INT, '0, 0, 0, 0, 1);
        push_row("one shot stopped", OP_RD, CSR_TVAL, 0, 0, '1, '1);
        push_row("one shot quiet", OP_INT, '0, 0, 0, 0, 1);
    endtask

    function automatic int longest_wait();
        int longest;
        longest = 0;
        foreach (steps[i]) begin
            if (steps[i].op == OP_WAIT && int'(steps[i].value) > longest) begin
                longest = int'(steps[i].value);
            end
        end
        return longest;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act, input logic [31:0] chk);
        assert ((act & chk) == (exp & chk)) else begin
            $display("FAILED %s expected %08h actual %08h", name, exp & chk, act & chk);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_for_int(input string name, input int limit);
        int waited;
        waited = 0;
        while (!has_int && waited < limit) begin
            @(negedge clk);
            #1;
            waited++;
        end
        assert (has_int) else begin
            $display("Interrupt did not arrive within %0d cycles in step %s", limit, name);
            $display("TEST FAILED");
            $fatal(1, "interrupt wait timed out");
        end
    endtask

    // Each row takes one cycle, checks sampled 1 ns after the falling edge
    task automatic run_step(input int idx);
        step_t s;
        s = steps[idx];
        @(negedge clk);
        csr_acc = '0;
        wb = '0;
        csr_acc.num = s.num;
        case (s.op)
            OP_WR: begin
                csr_acc.we = 1'b1;
                csr_acc.wmask = s.mask;
                csr_acc.wvalue = s.value;
            end
            OP_EXC: begin
                wb.ex = 1'b1;
                wb.ecode = s.ecode;
                wb.esubcode = s.esubcode;
                wb.pc = s.pc;
                wb.vaddr = s.vaddr;
            end
            OP_ERTN: wb.ertn = 1'b1;
            OP_IRQ: begin
                hw_int = s.value[7:0];
                ipi_int = s.value[8];
            end
            default: ;
        endcase
        #1;
        case (s.op)
            OP_RD:    check_value(names[idx], s.exp, csr_rvalue, s.chk);
            OP_INT:   check_value(names[idx], s.exp, {31'b0, has_int}, s.chk);
            OP_ENTRY: check_value(names[idx], s.exp, ex_entry, s.chk);
            OP_ERA:   check_value(names[idx], s.exp, era_pc, s.chk);
            OP_WAIT:  wait_for_int(names[idx], int'(s.value));
            default: ;
        endcase
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        csr_acc = '0;
        wb = '0;
        hw_int = '0;
        ipi_int = 1'b0;
        coreid = CORE_ID;
        lcg_state = 32'h5270f93c;
        table_ready = 1'b0;
        build_table();
        watchdog_cycles = 20 * steps.size() + longest_wait();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(i);
        end
        if (i_dut.i_int_ctrl.i_props.err_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d property checks failed", i_dut.i_int_ctrl.i_props.err_count);
            $display("TEST FAILED");
            $fatal(1, "property failure");
        end
    end

    initial begin
        wait (table_ready);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles without finishing", watchdog_cycles);
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule
